// File: Makefile
FLIST = c2c_master.f

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module c2c_master_tb -f $(FLIST)

sim:
	verilator --binary --timing --assert -j 0 --top-module c2c_master_tb -f $(FLIST) -o c2c_master_sim
	./obj_dir/c2c_master_sim | tee sim.log
	grep -q "^Test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: c2c_master.f
verilog/c2c_pkg.sv
verilog/button_pulse.sv
verilog/onehot_encoder.sv
verilog/hold_timer.sv
verilog/link_master_fsm.sv
verilog/digit_display.sv
verilog/c2c_master_top.sv
verif/tb_clock_gen.sv
verif/c2c_master_tb.sv

// File: verif/c2c_master_tb.sv
module c2c_master_tb;

    // short hold so the notice phase stays small in simulation
    localparam int HOLD       = 20;
    localparam int DEBOUNCE   = 4;
    localparam int REQ_LIMIT  = DEBOUNCE + 4;
    localparam int NOTICE_MIN = HOLD;
    localparam int NOTICE_MAX = HOLD + 3;

    logic       clk;
    logic       rst_n;
    logic       request;
    logic [7:0] switches;
    logic       ack;
    logic       request2s;
    logic       valid;
    logic [2:0] data_to_slave;
    logic       notice;
    logic [6:0] seven_seg;

    int          error_count   = 0;
    int          tests_clean   = 0;
    int          tests_failing = 0;
    logic [31:0] rng_state     = 32'd61;

    tb_clock_gen clock_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    c2c_master_top #(
        .HOLD_CYCLES    (HOLD),
        .DEBOUNCE_DEPTH (DEBOUNCE)
    ) dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .request       (request),
        .switches      (switches),
        .ack           (ack),
        .request2s     (request2s),
        .valid         (valid),
        .data_to_slave (data_to_slave),
        .notice        (notice),
        .seven_seg     (seven_seg)
    );

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    // 32-bit xorshift, 13/17/5
    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // common-anode digits, gfedcba, 0 lights a segment
    function automatic logic [6:0] expected_segments(input int digit);
        case (digit)
            1:       return 7'h79;
            2:       return 7'h24;
            3:       return 7'h30;
            4:       return 7'h19;
            5:       return 7'h12;
            6:       return 7'h02;
            7:       return 7'h78;
            default: return 7'h40;
        endcase
    endfunction

    // handshake outputs by name, for the wait loop
    function automatic logic probe(input string which);
        logic v;
        v = 1'bx;
        if (which == "request2s") begin
            v = request2s;
        end else if (which == "valid") begin
            v = valid;
        end else if (which == "notice") begin
            v = notice;
        end
        return v;
    endfunction

    task automatic check_value(input string name, input int got, input int exp);
        assert (got == exp) else begin
            $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp);
            error_count++;
        end
    endtask

    // bounded wait on negedges
    task automatic wait_level(input string which, input logic level, input int limit);
        int n;
        n = 0;
        while (probe(which) !== level && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (probe(which) !== level) begin
            $display("timeout: %s did not reach %0d within %0d cycles", which, level, limit);
            error_count++;
        end
    endtask

    // request2s must stay low
    task automatic expect_quiet(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            check_value("request2s", int'(request2s), 0);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (error_count == errs_before) begin
            tests_clean++;
            $display("%s: ok", name);
        end else begin
            tests_failing++;
            $display("%s: %0d errors", name, error_count - errs_before);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // one transfer, testbench acts as the slave
    ////////////////////////////////////////////////////////////

    task automatic do_transfer(input int idx, input int ack_delay, input int ack_hold,
                               input bit repress);
        int notice_len;
        @(negedge clk);
        switches = 8'(1 << idx);
        request  = 1'b1;
        wait_level("request2s", 1'b1, REQ_LIMIT);
        request = 1'b0;
        // slave stalls, request stays up
        for (int i = 0; i < ack_delay; i++) begin
            @(negedge clk);
            check_value("request2s", int'(request2s), 1);
        end
        ack = 1'b1;
        @(negedge clk);
        check_value("request2s", int'(request2s), 0);
        check_value("notice", int'(notice), 1);
        // measure the notice phase
        notice_len = 1;
        while (notice && notice_len <= NOTICE_MAX + 2) begin
            @(negedge clk);
            // second press while the hold runs, must be ignored
            if (repress && notice_len == 2) begin
                request = 1'b1;
            end
            if (repress && notice_len == 10) begin
                request = 1'b0;
            end
            if (notice) begin
                notice_len++;
            end
        end
        request = 1'b0;
        if (notice) begin
            $display("timeout: notice never fell after %0d cycles", notice_len);
            error_count++;
        end
        assert (notice_len >= NOTICE_MIN && notice_len <= NOTICE_MAX) else begin
            $display("MISMATCH notice length: got 0x%0h expected 0x%0h to 0x%0h",
                     notice_len, NOTICE_MIN, NOTICE_MAX);
            error_count++;
        end
        // valid comes up as notice drops
        check_value("valid", int'(valid), 1);
        check_value("data_to_slave", int'(data_to_slave), idx);
        for (int i = 0; i < ack_hold; i++) begin
            @(negedge clk);
            check_value("valid", int'(valid), 1);
            check_value("data_to_slave", int'(data_to_slave), idx);
        end
        // slave has the data, end the transfer
        ack = 1'b0;
        wait_level("valid", 1'b0, 4);
        check_value("data_to_slave", int'(data_to_slave), 0);
    endtask

    ////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////

    task automatic check_reset_state();
        check_value("request2s", int'(request2s), 0);
        check_value("valid", int'(valid), 0);
        check_value("notice", int'(notice), 0);
        check_value("data_to_slave", int'(data_to_slave), 0);
    endtask

    task automatic check_full_transfers();
        for (int t = 0; t < 10; t++) begin
            do_transfer(int'(next_random() % 32'd8), 0, 0, 1'b0);
        end
    endtask

    // eight one-hot words, then all-zero and a two-hot word
    task automatic check_display();
        logic [7:0] word;
        int         exp_idx;
        for (int i = 0; i < 10; i++) begin
            if (i < 8) begin
                word    = 8'(1 << i);
                exp_idx = i;
            end else if (i == 8) begin
                word    = 8'h00;
                exp_idx = 0;
            end else begin
                word    = 8'b0010_0100;
                exp_idx = 0;
            end
            @(negedge clk);
            switches = word;
            @(posedge clk);
            check_value("seven_seg", int'(seven_seg), int'(expected_segments(exp_idx)));
        end
    endtask

    task automatic check_back_pressure();
        do_transfer(int'(next_random() % 32'd8), 50, 40, 1'b0);
    endtask

    task automatic check_notice_filter();
        do_transfer(int'(next_random() % 32'd8), 0, 0, 1'b1);
        expect_quiet(20);
        // glitch shorter than the debounce depth
        @(negedge clk);
        request = 1'b1;
        repeat (2) @(negedge clk);
        request = 1'b0;
        expect_quiet(20);
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int errs;
        int n;
        request  = 1'b0;
        switches = '0;
        ack      = 1'b0;
        n        = 0;
        while (rst_n !== 1'b1 && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            $display("timeout: reset was never released");
            error_count++;
        end
        @(negedge clk);
        errs = error_count;
        check_reset_state();
        report_test("reset state", errs);
        errs = error_count;
        check_full_transfers();
        report_test("full transfer", errs);
        errs = error_count;
        check_display();
        report_test("display", errs);
        errs = error_count;
        check_back_pressure();
        report_test("back-pressure", errs);
        errs = error_count;
        check_notice_filter();
        report_test("notice and filtering", errs);
        $display("summary: %0d clean, %0d failing, %0d errors",
                 tests_clean, tests_failing, error_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: verif/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // period of 100 time units
    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // hold reset for 8 rising edges, release away from the edge
    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// File: verilog/button_pulse.sv
module button_pulse #(
    parameter int DEBOUNCE_DEPTH = 4
) (
    input  logic clk,
    input  logic rst_n,
    input  logic request,
    output logic request_pulse
);

    // sample history, newest in bit 0
    logic [DEBOUNCE_DEPTH-1:0] sample_q;
    logic                      stable;
    logic                      stable_q;

    // stable only once every stage saw the button high
    assign stable = &sample_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sample_q      <= '0;
            stable_q      <= 1'b0;
            request_pulse <= 1'b0;
        end else begin
            sample_q      <= {sample_q[DEBOUNCE_DEPTH-2:0], request};
            stable_q      <= stable;
            // rising edge of the debounced level
            request_pulse <= stable & ~stable_q;
        end
    end

endmodule

// File: verilog/c2c_master_top.sv
module c2c_master_top #(
    parameter int HOLD_CYCLES    = 100_000_000,
    parameter int DEBOUNCE_DEPTH = 4
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         request,
    input  logic [c2c_pkg::SWITCH_W-1:0] switches,
    input  logic                         ack,
    output logic                         request2s,
    output logic                         valid,
    output c2c_pkg::data_t               data_to_slave,
    output logic                         notice,
    output logic [c2c_pkg::SEG_W-1:0]    seven_seg
);

    import c2c_pkg::*;

    logic  request_pulse;
    data_t switch_digit;
    logic  timer_start;
    logic  timer_done;

    // button path
    button_pulse #(
        .DEBOUNCE_DEPTH (DEBOUNCE_DEPTH)
    ) button_pulse_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .request       (request),
        .request_pulse (request_pulse)
    );

    // switches to digit, shared by link and display
    onehot_encoder onehot_encoder_i (
        .switches     (switches),
        .switch_digit (switch_digit)
    );

    link_master_fsm link_master_fsm_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .request_pulse (request_pulse),
        .ack           (ack),
        .timer_done    (timer_done),
        .switch_digit  (switch_digit),
        .request2s     (request2s),
        .notice        (notice),
        .valid         (valid),
        .timer_start   (timer_start),
        .data_to_slave (data_to_slave)
    );

    // notice hold time
    hold_timer #(
        .HOLD_CYCLES (HOLD_CYCLES)
    ) hold_timer_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .timer_start (timer_start),
        .timer_done  (timer_done)
    );

    digit_display digit_display_i (
        .switch_digit (switch_digit),
        .seven_seg    (seven_seg)
    );

endmodule

// File: verilog/c2c_pkg.sv
package c2c_pkg;

    ////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////

    // one-hot switch bank on the master board
    localparam int SWITCH_W = 8;
    // encoded digit carried over the link
    localparam int DATA_W   = 3;
    // segment lines a..g
    localparam int SEG_W    = 7;

    typedef logic [DATA_W-1:0] data_t;

    // master side of the link handshake
    typedef enum logic [1:0] {
        st_wait_rqst = 2'b00,  // idle, waiting for button
        st_wait_ack  = 2'b01,  // request2s out
        st_hold      = 2'b10,  // notice lit, timer running
        st_send      = 2'b11   // data valid on the link
    } master_state_t;

    ////////////////////////////////////////////////////////////
    // seven-segment patterns
    ////////////////////////////////////////////////////////////

    // active low, bit 0 = a, bit 6 = g
    // a set bit means the segment stays dark
    localparam logic [SEG_W-1:0] SEG_PATTERN [2**DATA_W] = '{
        7'b100_0000,  // 0
        7'b111_1001,  // 1
        7'b010_0100,  // 2
        7'b011_0000,  // 3
        7'b001_1001,  // 4
        7'b001_0010,  // 5
        7'b000_0010,  // 6
        7'b111_1000   // 7
    };

endpackage

// File: verilog/digit_display.sv
module digit_display (
    input  c2c_pkg::data_t             switch_digit,
    output logic [c2c_pkg::SEG_W-1:0]  seven_seg
);

    import c2c_pkg::*;

    localparam int DIGITS = 2 ** DATA_W;

    // one line per digit
    logic [DIGITS-1:0] digit_onehot;

    ////////////////////////////////////////////////////////////
    // binary to one-hot
    ////////////////////////////////////////////////////////////

    always_comb begin
        digit_onehot               = '0;
        digit_onehot[switch_digit] = 1'b1;
    end

    ////////////////////////////////////////////////////////////
    // one-hot to segments
    ////////////////////////////////////////////////////////////

    // a segment goes dark when any digit that blanks it is active
    always_comb begin
        seven_seg = '0;
        for (int d = 0; d < DIGITS; d++) begin
            for (int s = 0; s < SEG_W; s++) begin
                if (SEG_PATTERN[d][s]) begin
                    seven_seg[s] = seven_seg[s] | digit_onehot[d];
                end
            end
        end
    end

endmodule

// File: verilog/hold_timer.sv
module hold_timer #(
    parameter int HOLD_CYCLES = 100_000_000
) (
    input  logic clk,
    input  logic rst_n,
    input  logic timer_start,
    output logic timer_done
);

    // wide enough to hold the terminal count itself
    localparam int CNT_W = $clog2(HOLD_CYCLES + 1);
    localparam logic [CNT_W-1:0] LAST_COUNT = CNT_W'(HOLD_CYCLES);

    logic [CNT_W-1:0] count_q;

    assign timer_done = timer_start && (count_q == LAST_COUNT);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (!timer_start || timer_done) begin
            // idle or wrapped, start over from zero
            count_q <= '0;
        end else begin
            count_q <= count_q + 1'b1;
        end
    end

    // done is a one-cycle pulse, the count restarts after it
    a_done_single_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        timer_done |=> !timer_done
    ) else $error("hold_timer: done held for more than one cycle");

endmodule

// File: verilog/link_master_fsm.sv
module link_master_fsm (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           request_pulse,
    input  logic           ack,
    input  logic           timer_done,
    input  c2c_pkg::data_t switch_digit,
    output logic           request2s,
    output logic           notice,
    output logic           valid,
    output logic           timer_start,
    output c2c_pkg::data_t data_to_slave
);

    import c2c_pkg::*;

    master_state_t state_q;
    master_state_t state_d;
    logic          request2s_d;
    logic          notice_d;
    logic          valid_d;
    logic          timer_start_d;
    data_t         data_d;

    ////////////////////////////////////////////////////////////
    // next state and next outputs
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_d       = state_q;
        request2s_d   = 1'b0;
        notice_d      = 1'b0;
        valid_d       = 1'b0;
        timer_start_d = 1'b0;
        data_d        = '0;
        case (state_q)
            st_wait_rqst: begin
                // one debounced press opens a transfer
                if (request_pulse) begin
                    state_d     = st_wait_ack;
                    request2s_d = 1'b1;
                end
            end
            st_wait_ack: begin
                if (ack) begin
                    state_d       = st_hold;
                    notice_d      = 1'b1;
                    timer_start_d = 1'b1;
                end else begin
                    // keep asking until the slave answers
                    request2s_d = 1'b1;
                end
            end
            st_hold: begin
                if (timer_done) begin
                    state_d = st_send;
                    valid_d = 1'b1;
                    data_d  = switch_digit;
                end else begin
                    notice_d      = 1'b1;
                    timer_start_d = 1'b1;
                end
            end
            st_send: begin
                // slave drops ack once it has the data
                if (!ack) begin
                    state_d = st_wait_rqst;
                end else begin
                    valid_d = 1'b1;
                    data_d  = switch_digit;
                end
            end
            default: begin
                state_d = st_wait_rqst;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // registered outputs
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q       <= st_wait_rqst;
            request2s     <= 1'b0;
            notice        <= 1'b0;
            valid         <= 1'b0;
            timer_start   <= 1'b0;
            data_to_slave <= '0;
        end else begin
            state_q       <= state_d;
            request2s     <= request2s_d;
            notice        <= notice_d;
            valid         <= valid_d;
            timer_start   <= timer_start_d;
            data_to_slave <= data_d;
        end
    end

    // link phases never overlap on the wires
    a_valid_vs_request: assert property (
        @(posedge clk) disable iff (!rst_n) !(valid && request2s)
    ) else $error("link_master_fsm: valid and request2s together");

    a_notice_vs_valid: assert property (
        @(posedge clk) disable iff (!rst_n) !(notice && valid)
    ) else $error("link_master_fsm: notice and valid together");

    // bus idles at zero outside the data phase
    a_data_idle_zero: assert property (
        @(posedge clk) disable iff (!rst_n) !valid |-> (data_to_slave == '0)
    ) else $error("link_master_fsm: data driven while not valid");

endmodule

// File: verilog/onehot_encoder.sv
module onehot_encoder (
    input  logic [c2c_pkg::SWITCH_W-1:0] switches,
    output c2c_pkg::data_t               switch_digit
);

    import c2c_pkg::*;

    logic is_onehot;

    // nonzero and clearing the lowest set bit leaves nothing
    assign is_onehot = (|switches) && !(|(switches & (switches - 1'b1)));

    always_comb begin
        switch_digit = '0;
        // zero or multi-hot words fall back to digit 0
        if (is_onehot) begin
            for (int i = 0; i < SWITCH_W; i++) begin
                if (switches[i]) begin
                    switch_digit = data_t'(i);
                end
            end
        end
    end

endmodule
